/* verilog.f */
ice_ctrl_pkg.sv
frame_if.sv
spi_msg_rx.sv
spi_cmd_decoder.sv
spi_resp_tx.sv
cmd6_capture.sv
ice_ctrl_top.sv
tb_ice_ctrl.sv

/* tb_ice_ctrl.sv */
module tb_ice_ctrl;
    timeunit 1ns;
    timeprecision 1ps;

    import ice_ctrl_pkg::*;

    localparam int turnaround_cycles = 8;
    localparam int clk_period        = 100;
    localparam int watch_cycles      = turnaround_cycles + resp_len + 4;   // Past the deaf cycle
    localparam int frame_cycles      = 1 + msg_len + watch_cycles;
    localparam int n_frames          = 13;
    localparam int cmd6_words        = blk_words + 8;
    localparam int limit_cycles      = n_frames * frame_cycles + cmd6_words + 200;

    logic      sd_datInWrite_clk;
    logic      sd_datInWrite_rst_;
    logic      spi_data_in;
    logic      spi_data_out;
    logic      spi_data_oe;
    logic      dat_in_trigger;
    dat_word_t dat_in_data;
    led_t      led;

    logic        frame_end;     // High for the cycle after edge T
    logic        frame_resp;    // Opcode bit 7 of that frame
    logic [31:0] lfsr_q;
    int          err_cnt   = 0;
    int          tests_ok  = 0;
    int          tests_bad = 0;

    ice_ctrl_top #(
        .turnaround_cycles  (turnaround_cycles)
    ) dut_i (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .spi_data_in        (spi_data_in),
        .spi_data_out       (spi_data_out),
        .spi_data_oe        (spi_data_oe),
        .dat_in_trigger     (dat_in_trigger),
        .dat_in_data        (dat_in_data),
        .led                (led)
    );

    always #(clk_period / 2) sd_datInWrite_clk = ~sd_datInWrite_clk;

    // ====================
    // Timing assertions
    // ====================
    // First response bit goes out a fixed turnaround after the last message bit
    turnaround_a: assert property (@(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        frame_end && frame_resp |-> ##(turnaround_cycles) $rose(spi_data_oe))
    else begin
        $display("Timing error at %0t: spi_data_oe did not rise %0d cycles after edge T",
                 $time, turnaround_cycles);
        err_cnt++;
    end

    oe_length_a: assert property (@(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        $rose(spi_data_oe) |-> ##(resp_len) $fell(spi_data_oe))
    else begin
        $display("Timing error at %0t: spi_data_oe was not high for %0d cycles",
                 $time, resp_len);
        err_cnt++;
    end

    reset_a: assert property (@(posedge sd_datInWrite_clk)
        !sd_datInWrite_rst_ |-> !spi_data_oe && (led == '0))
    else begin
        $display("Reset error at %0t: spi_data_oe or led not cleared during reset", $time);
        err_cnt++;
    end

    // ====================
    // Helpers
    // ====================
    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            v      = {v[62:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act === exp) else begin
            $display("ERR %0t %s expected %0h got %0h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            tests_ok++;
            $display("Test %s: ok", name);
        end else begin
            tests_bad++;
            $display("Test %s: FAILED with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    // Start bit, 64 bits MSB first, then watch the response window
    task automatic send_frame(input logic [7:0] opcode, input msg_arg_t arg,
                              output resp_t resp, output int oe_cycles,
                              output int first_oe, output led_t led_t2);
        msg_t msg;
        msg       = {opcode, arg};
        resp      = '0;
        oe_cycles = 0;
        first_oe  = -1;
        led_t2    = '0;
        @(posedge sd_datInWrite_clk);
        spi_data_in <= 1'b1;
        for (int i = msg_len - 1; i >= 0; i--) begin
            @(posedge sd_datInWrite_clk);
            spi_data_in <= msg[i];
        end
        @(posedge sd_datInWrite_clk);               // Edge T takes bit 0
        spi_data_in <= 1'b0;
        frame_end   <= 1'b1;
        frame_resp  <= opcode[7];
        for (int k = 0; k < watch_cycles; k++) begin
            @(negedge sd_datInWrite_clk);           // Values after edge T+k
            if (k == 1) begin
                frame_end <= 1'b0;
            end
            if (k == 2) begin
                led_t2 = led;
            end
            if (spi_data_oe) begin
                if (first_oe < 0) begin
                    first_oe = k;
                end
                resp = {resp[resp_len-2:0], spi_data_out};
                oe_cycles++;
            end
        end
    endtask

    task automatic check_response(input resp_t exp, input resp_t resp,
                                  input int oe_cycles, input int first_oe);
        check_value("spi_data_oe high cycles", resp_len, oe_cycles);
        check_value("spi_data_oe first cycle", turnaround_cycles, first_oe);
        check_value("spi_data_out response", exp, resp);
    endtask

    // Word at mode_at gets the access-mode nibble, -1 for none
    task automatic send_words(input int count, input int mode_at, input access_mode_t mode);
        dat_word_t w;
        for (int i = 0; i < count; i++) begin
            w = dat_word_t'(rand_bits(16));
            if (i == mode_at) begin
                w[11:8] = mode;
            end
            @(posedge sd_datInWrite_clk);
            dat_in_trigger <= 1'b1;
            dat_in_data    <= w;
        end
        @(posedge sd_datInWrite_clk);
        dat_in_trigger <= 1'b0;
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        resp_t        resp;
        int           oe_cycles;
        int           first_oe;
        led_t         led_seen;
        led_t         led_prev;
        msg_arg_t     arg;
        access_mode_t mode;
        int           k;
        int           errs;

        lfsr_q             = 32'hf2ed;
        sd_datInWrite_clk  = 1'b0;
        sd_datInWrite_rst_ <= 1'b0;
        spi_data_in        <= 1'b0;
        dat_in_trigger     <= 1'b0;
        dat_in_data        <= '0;
        frame_end          <= 1'b0;
        frame_resp         <= 1'b0;
        repeat (5) @(posedge sd_datInWrite_clk);
        sd_datInWrite_rst_ <= 1'b1;

        errs = err_cnt;
        @(negedge sd_datInWrite_clk);
        check_value("spi_data_oe", 0, spi_data_oe);
        check_value("led", 0, led);
        send_frame(msg_nop, msg_arg_t'(rand_bits(56)), resp, oe_cycles, first_oe, led_seen);
        check_value("spi_data_oe high cycles", 0, oe_cycles);
        check_value("led", 0, led_seen);
        end_test("reset_and_nop", errs);

        errs = err_cnt;
        repeat (4) begin
            arg = msg_arg_t'(rand_bits(56));
            send_frame(msg_led_set, arg, resp, oe_cycles, first_oe, led_seen);
            check_value("led", arg[3:0], led_seen);
            check_value("spi_data_oe high cycles", 0, oe_cycles);
        end
        end_test("led_set", errs);

        errs = err_cnt;
        repeat (4) begin
            arg = msg_arg_t'(rand_bits(56));
            send_frame(msg_echo, arg, resp, oe_cycles, first_oe, led_seen);
            check_response({arg, 8'h00}, resp, oe_cycles, first_oe);
        end
        end_test("echo", errs);

        // Full block with the nibble at word 8, then a short block
        errs = err_cnt;
        mode = 4'ha;
        k    = int'(rand_bits(3)) + 1;              // Stays below word 8
        send_words(blk_words, access_mode_word, mode);
        send_words(k, -1, mode);
        send_frame(msg_cmd6_status, msg_arg_t'(rand_bits(56)), resp, oe_cycles, first_oe,
                   led_seen);
        check_response({mode, word_idx_t'(k), {(resp_len - 4 - word_idx_len){1'b0}}},
                       resp, oe_cycles, first_oe);
        end_test("cmd6_status", errs);

        errs     = err_cnt;
        led_prev = led;
        send_frame(8'hc3, msg_arg_t'(rand_bits(56)), resp, oe_cycles, first_oe, led_seen);
        check_response('0, resp, oe_cycles, first_oe);
        send_frame(8'h42, msg_arg_t'(rand_bits(56)), resp, oe_cycles, first_oe, led_seen);
        check_value("spi_data_oe high cycles", 0, oe_cycles);
        check_value("led", led_prev, led_seen);
        arg = msg_arg_t'(rand_bits(56));
        send_frame(msg_echo, arg, resp, oe_cycles, first_oe, led_seen);
        check_response({arg, 8'h00}, resp, oe_cycles, first_oe);
        end_test("unknown_opcodes", errs);

        $display("Tests ok: %0d, tests failed: %0d, errors: %0d", tests_ok, tests_bad, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog sized from the frame and word counts above
    initial begin
        #(limit_cycles * clk_period);
        $display("Timeout after %0d clock cycles, the test sequence did not finish",
                 limit_cycles);
        $display("Regression failed");
        $finish;
    end

endmodule

/* ice_ctrl_top.sv */
module ice_ctrl_top #(
    parameter int turnaround_cycles = 8
) (
    input  logic                    sd_datInWrite_clk,
    input  logic                    sd_datInWrite_rst_,

    // Serial command line, tristate lives on the board
    input  logic                    spi_data_in,
    output logic                    spi_data_out,
    output logic                    spi_data_oe,

    // SD data-in word stream
    input  logic                    dat_in_trigger,
    input  ice_ctrl_pkg::dat_word_t dat_in_data,

    output ice_ctrl_pkg::led_t      led
);
    import ice_ctrl_pkg::*;

    access_mode_t access_mode;
    word_idx_t    word_idx;

    frame_if frm ();

    // ====================
    // Message receive
    // ====================
    spi_msg_rx spi_msg_rx_i (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .spi_data_in        (spi_data_in),
        .frm                (frm.rx)
    );

    // ====================
    // Command decode
    // ====================
    spi_cmd_decoder spi_cmd_decoder_i (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .frm                (frm.dec),
        .access_mode        (access_mode),
        .word_idx           (word_idx),
        .led                (led)
    );

    // ====================
    // Response transmit
    // ====================
    spi_resp_tx #(
        .turnaround_cycles  (turnaround_cycles)
    ) spi_resp_tx_i (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .frm                (frm.tx),
        .spi_data_out       (spi_data_out),
        .spi_data_oe        (spi_data_oe)
    );

    // ====================
    // CMD6 capture
    // ====================
    cmd6_capture cmd6_capture_i (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .dat_in_trigger     (dat_in_trigger),
        .dat_in_data        (dat_in_data),
        .access_mode        (access_mode),
        .word_idx           (word_idx)      // Also reported by CMD6 status
    );

endmodule

/* cmd6_capture.sv */
module cmd6_capture (
    input  logic                       sd_datInWrite_clk,
    input  logic                       sd_datInWrite_rst_,
    input  logic                       dat_in_trigger,
    input  ice_ctrl_pkg::dat_word_t    dat_in_data,
    output ice_ctrl_pkg::access_mode_t access_mode,
    output ice_ctrl_pkg::word_idx_t    word_idx
);
    import ice_ctrl_pkg::*;

    logic last_word;
    logic mode_word;

    assign last_word = (word_idx == word_idx_t'(blk_words - 1));
    assign mode_word = (word_idx == word_idx_t'(access_mode_word));

    // ====================
    // Word counter
    // ====================
    // One status block is 32 words, counter wraps for the next block
    always_ff @(posedge sd_datInWrite_clk, negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            word_idx <= '0;
        end else if (dat_in_trigger) begin
            if (last_word) begin
                word_idx <= '0;
            end else begin
                word_idx <= word_idx + 1'b1;
            end
        end
    end

    // ====================
    // Access mode nibble
    // ====================
    always_ff @(posedge sd_datInWrite_clk, negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            access_mode <= '0;
        end else if (dat_in_trigger && mode_word) begin
            // Function group 1 result
            access_mode <= dat_in_data[access_mode_lsb +: $bits(access_mode_t)];
        end
    end

endmodule

/* spi_resp_tx.sv */
module spi_resp_tx #(
    parameter int turnaround_cycles = 8     // At least 3
) (
    input  logic sd_datInWrite_clk,
    input  logic sd_datInWrite_rst_,
    frame_if.tx  frm,
    output logic spi_data_out,
    output logic spi_data_oe
);
    import ice_ctrl_pkg::*;

    // Receiver and decoder already use two of the turnaround cycles
    localparam int wait_w = $clog2(turnaround_cycles);
    localparam int bit_w  = $clog2(resp_len);

    typedef enum logic [1:0] {
        tx_idle,
        tx_wait,
        tx_shift
    } tx_state_e;

    tx_state_e         state;
    logic [wait_w-1:0] wait_cnt;
    logic [bit_w-1:0]  bit_cnt;
    logic              take_bit;
    resp_t             shift_q;

    // A new bit goes out on the first shift edge and on every edge but the last
    assign take_bit = ((state == tx_wait) && (wait_cnt == '0)) ||
                      ((state == tx_shift) && (bit_cnt != '0));

    assign frm.tx_busy = frm.resp_load || (state != tx_idle);

    always_ff @(posedge sd_datInWrite_clk, negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            state        <= tx_idle;
            wait_cnt     <= '0;
            bit_cnt      <= '0;
            spi_data_oe  <= 1'b0;
            spi_data_out <= 1'b0;
        end else begin
            case (state)
            tx_idle: begin
                if (frm.resp_load) begin
                    wait_cnt <= wait_w'(turnaround_cycles - 3);
                    state    <= tx_wait;
                end
            end
            tx_wait: begin
                if (wait_cnt == '0) begin
                    bit_cnt <= bit_w'(resp_len - 1);
                    state   <= tx_shift;
                end else begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
            end
            tx_shift: begin
                if (bit_cnt == '0) begin
                    state <= tx_idle;   // Release the line
                end else begin
                    bit_cnt <= bit_cnt - 1'b1;
                end
            end
            default: state <= tx_idle;
            endcase

            if (take_bit) begin
                spi_data_oe  <= 1'b1;
                spi_data_out <= shift_q[resp_len-1];
            end else if (state == tx_shift) begin
                spi_data_oe  <= 1'b0;
                spi_data_out <= 1'b0;
            end
        end
    end

    always_ff @(posedge sd_datInWrite_clk) begin
        if ((state == tx_idle) && frm.resp_load) begin
            shift_q <= frm.resp;
        end else if (take_bit) begin
            shift_q <= {shift_q[resp_len-2:0], 1'b0};
        end
    end

endmodule

/* spi_cmd_decoder.sv */
module spi_cmd_decoder (
    input  logic                       sd_datInWrite_clk,
    input  logic                       sd_datInWrite_rst_,
    frame_if.dec                       frm,
    input  ice_ctrl_pkg::access_mode_t access_mode,
    input  ice_ctrl_pkg::word_idx_t    word_idx,
    output ice_ctrl_pkg::led_t         led
);
    import ice_ctrl_pkg::*;

    localparam int echo_pad = resp_len - msg_arg_len;
    localparam int cmd6_pad = resp_len - $bits(access_mode_t) - word_idx_len;

    msg_type_e msg_type;
    msg_arg_t  msg_arg;
    logic      resp_wanted;
    resp_t     resp_next;
    resp_t     resp_q;

    assign msg_type    = msg_type_of(frm.msg);
    assign msg_arg     = msg_arg_of(frm.msg);
    assign resp_wanted = msg_resp_wanted(frm.msg);

    // ====================
    // Response word
    // ====================
    always_comb begin
        resp_next = '0;

        case (msg_type)
        msg_echo: begin
            // Argument moves up to the top, low byte stays clear
            resp_next = {msg_arg, {echo_pad{1'b0}}};
        end

        msg_cmd6_status: begin
            resp_next = {access_mode, word_idx, {cmd6_pad{1'b0}}};
        end

        msg_nop,
        msg_led_set: begin
            resp_next = '0;     // No response sent
        end

        default: begin
            // Unknown opcodes act as Nop
            // They still answer zeros when bit 7 asks for it
            resp_next = '0;
        end
        endcase
    end

    // ====================
    // LED and load strobe
    // ====================
    always_ff @(posedge sd_datInWrite_clk, negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            led           <= '0;
            frm.resp_load <= 1'b0;
        end else begin
            frm.resp_load <= 1'b0;

            if (frm.msg_valid) begin
                frm.resp_load <= resp_wanted;

                if (msg_type == msg_led_set) begin
                    led <= msg_arg[led_len-1:0];
                end
            end
        end
    end

    // Captured with the strobe so CMD6 state can move on afterwards
    always_ff @(posedge sd_datInWrite_clk) begin
        if (frm.msg_valid) begin
            resp_q <= resp_next;
        end
    end

    assign frm.resp = resp_q;

endmodule

/* spi_msg_rx.sv */
module spi_msg_rx (
    input  logic sd_datInWrite_clk,
    input  logic sd_datInWrite_rst_,
    input  logic spi_data_in,
    frame_if.rx  frm
);
    import ice_ctrl_pkg::*;

    localparam int cnt_w = $clog2(msg_len);

    rx_state_e        state;
    logic [cnt_w-1:0] bit_cnt;      // Bits still to come, minus one
    logic             busy_q;
    logic             deaf;
    msg_t             shift_q;

    // Line belongs to the transmitter, plus one cycle of settling
    assign deaf = frm.tx_busy || busy_q;

    // ====================
    // Frame FSM
    // ====================
    always_ff @(posedge sd_datInWrite_clk, negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            state         <= rx_idle;
            bit_cnt       <= '0;
            busy_q        <= 1'b0;
            frm.msg_valid <= 1'b0;
        end else begin
            busy_q        <= frm.tx_busy;
            frm.msg_valid <= 1'b0;

            case (state)
            rx_idle: begin
                // First high bit marks the start
                if (!deaf && spi_data_in) begin
                    bit_cnt <= cnt_w'(msg_len - 1);
                    state   <= rx_shift;
                end
            end

            rx_shift: begin
                if (bit_cnt == '0) begin
                    frm.msg_valid <= 1'b1;  // Bit 0 just taken
                    state         <= rx_idle;
                end else begin
                    bit_cnt <= bit_cnt - 1'b1;
                end
            end

            default: begin
                state <= rx_idle;
            end
            endcase
        end
    end

    // ====================
    // Message shifter
    // ====================
    // MSB first, so the oldest bit ends up at the top
    always_ff @(posedge sd_datInWrite_clk) begin
        if (state == rx_shift) begin
            shift_q <= {shift_q[msg_len-2:0], spi_data_in};
        end
    end

    // Held until the next frame starts shifting
    assign frm.msg = shift_q;

endmodule

/* frame_if.sv */
interface frame_if;
    import ice_ctrl_pkg::*;

    // Receiver to decoder
    logic  msg_valid;   // One-cycle strobe
    msg_t  msg;

    // Decoder to transmitter
    logic  resp_load;   // One-cycle strobe
    resp_t resp;

    // Back from the transmitter, keeps the receiver quiet
    logic  tx_busy;

    modport rx (
        output msg_valid,
        output msg,
        input  tx_busy
    );

    modport dec (
        input  msg_valid,
        input  msg,
        output resp_load,
        output resp
    );

    modport tx (
        input  resp_load,
        input  resp,
        output tx_busy
    );

endinterface

/* ice_ctrl_pkg.sv */
package ice_ctrl_pkg;

    // ====================
    // Message layout
    // ====================
    localparam int msg_len      = 64;
    localparam int resp_len     = 64;
    localparam int msg_type_len = 8;                    // Opcode in the top byte
    localparam int msg_arg_len  = msg_len - msg_type_len;
    localparam int msg_resp_bit = 7;                    // Opcode bit asking for a response

    typedef logic [msg_len-1:0]     msg_t;
    typedef logic [resp_len-1:0]    resp_t;
    typedef logic [msg_arg_len-1:0] msg_arg_t;

    typedef enum logic [msg_type_len-1:0] {
        msg_nop         = 8'h00,
        msg_led_set     = 8'h01,
        msg_echo        = 8'h80,
        msg_cmd6_status = 8'h82
    } msg_type_e;

    // Opcode field of a message, unknown codes pass through unchanged
    function automatic msg_type_e msg_type_of(input msg_t m);
        return msg_type_e'(m[msg_len-1 -: msg_type_len]);
    endfunction

    function automatic logic msg_resp_wanted(input msg_t m);
        logic [msg_type_len-1:0] op;
        op = m[msg_len-1 -: msg_type_len];
        return op[msg_resp_bit];
    endfunction

    function automatic msg_arg_t msg_arg_of(input msg_t m);
        return m[msg_arg_len-1:0];
    endfunction

    // ====================
    // LED and CMD6
    // ====================
    localparam int led_len = 4;
    typedef logic [led_len-1:0] led_t;

    typedef logic [15:0] dat_word_t;

    localparam int blk_words        = 32;   // 512-bit status block
    localparam int access_mode_word = 8;
    localparam int access_mode_lsb  = 8;    // Nibble sits in bits 11..8
    localparam int word_idx_len     = $clog2(blk_words);

    typedef logic [3:0]              access_mode_t;
    typedef logic [word_idx_len-1:0] word_idx_t;

    // Receiver FSM
    typedef enum logic {
        rx_idle,
        rx_shift
    } rx_state_e;

endpackage
